// File: cu_pkg.sv
package cu_pkg;

    //////////////////////////////
    // bus and data widths
    //////////////////////////////

    localparam int csr_addr_w = 6;
    localparam int csr_data_w = 32;

    // one bus word
    typedef logic [csr_data_w-1:0] csr_data_t;
    // layer dimension, also used for loop indices
    typedef logic [15:0] dim_t;
    // element address into ifm, weight or ofm memory
    typedef logic [31:0] addr_t;
    // total step count of a layer
    typedef logic [31:0] count_t;

    //////////////////////////////
    // register offsets (bytes)
    //////////////////////////////

    localparam logic [csr_addr_w-1:0] off_in_height = 6'h00;
    localparam logic [csr_addr_w-1:0] off_in_width  = 6'h04;
    localparam logic [csr_addr_w-1:0] off_in_ch     = 6'h08;
    localparam logic [csr_addr_w-1:0] off_out_ch    = 6'h0C;
    localparam logic [csr_addr_w-1:0] off_cfg       = 6'h10;
    localparam logic [csr_addr_w-1:0] off_ifm_base  = 6'h14;
    localparam logic [csr_addr_w-1:0] off_wgt_base  = 6'h18;
    localparam logic [csr_addr_w-1:0] off_ofm_base  = 6'h1C;
    // bit 0 is start, self clearing
    localparam logic [csr_addr_w-1:0] off_ctrl      = 6'h20;
    // busy, done and error
    localparam logic [csr_addr_w-1:0] off_status    = 6'h24;

    // kernel/stride/type word, seen raw or split into fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [3:0] layer_type;
            logic [3:0] kernel_size;
            logic [3:0] stride;
            logic       relu_en;
            logic       pool_en;
            logic [1:0] rsvd;
        } f;
    } cfg_word_u;

    // status bit positions
    localparam int stat_busy_bit  = 0;
    localparam int stat_done_bit  = 1;
    localparam int stat_error_bit = 2;

    //////////////////////////////
    // sequencer FSM encoding
    //////////////////////////////

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_setup = 2'd1;
    localparam logic [1:0] st_run   = 2'd2;
    localparam logic [1:0] st_drain = 2'd3;

endpackage

// File: cu_config_csrs.sv
`timescale 1ns/1ps

module cu_config_csrs (
    input  logic                          clk,
    input  logic                          rst,
    // chip-select bus
    input  logic                          cs,
    input  logic                          we,
    input  logic [cu_pkg::csr_addr_w-1:0] addr,
    input  cu_pkg::csr_data_t             wdata,
    output cu_pkg::csr_data_t             rdata,
    // status from the sequencer
    input  logic                          busy,
    input  logic                          done,
    input  logic                          error,
    // layer fields
    output cu_pkg::dim_t                  in_height,
    output cu_pkg::dim_t                  in_width,
    output cu_pkg::dim_t                  in_ch,
    output cu_pkg::dim_t                  out_ch,
    output logic [3:0]                    layer_type,
    output logic [3:0]                    kernel_size,
    output logic [3:0]                    stride,
    output logic                          relu_en,
    output logic                          pool_en,
    output cu_pkg::addr_t                 ifm_base,
    output cu_pkg::addr_t                 wgt_base,
    output cu_pkg::addr_t                 ofm_base,
    output logic                          start
);
    import cu_pkg::*;

    cfg_word_u cfg_q;
    logic      done_q;
    logic      error_q;
    logic      wr_en;
    csr_data_t status_word;

    assign wr_en = cs && we;

    // cfg word split through the union field view
    assign layer_type  = cfg_q.f.layer_type;
    assign kernel_size = cfg_q.f.kernel_size;
    assign stride      = cfg_q.f.stride;
    assign relu_en     = cfg_q.f.relu_en;
    assign pool_en     = cfg_q.f.pool_en;

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_height <= '0;
            in_width  <= '0;
            in_ch     <= '0;
            out_ch    <= '0;
            cfg_q     <= '0;
            ifm_base  <= '0;
            wgt_base  <= '0;
            ofm_base  <= '0;
        end else if (wr_en) begin
            // unlisted offsets fall through, nothing stored
            case (addr)
                off_in_height: in_height <= wdata[15:0];
                off_in_width:  in_width  <= wdata[15:0];
                off_in_ch:     in_ch     <= wdata[15:0];
                off_out_ch:    out_ch    <= wdata[15:0];
                off_cfg:       cfg_q.raw <= wdata[15:0];
                off_ifm_base:  ifm_base  <= wdata;
                off_wgt_base:  wgt_base  <= wdata;
                off_ofm_base:  ofm_base  <= wdata;
                default: ;
            endcase
        end
    end

    // start pulse, one cycle, dropped while a layer runs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= wr_en && (addr == off_ctrl) && wdata[0] && !busy && !start;
        end
    end

    // sticky done/error, a new start clears both
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            if (done) begin
                done_q <= 1'b1;
            end else if (start) begin
                done_q <= 1'b0;
            end
            if (error) begin
                error_q <= 1'b1;
            end else if (start) begin
                error_q <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    always_comb begin
        status_word                 = '0;
        status_word[stat_busy_bit]  = busy;
        status_word[stat_done_bit]  = done_q;
        status_word[stat_error_bit] = error_q;
    end

    always_comb begin
        rdata = '0;
        if (cs && !we) begin
            case (addr)
                off_in_height: rdata = {16'h0, in_height};
                off_in_width:  rdata = {16'h0, in_width};
                off_in_ch:     rdata = {16'h0, in_ch};
                off_out_ch:    rdata = {16'h0, out_ch};
                off_cfg:       rdata = {16'h0, cfg_q.raw};
                off_ifm_base:  rdata = ifm_base;
                off_wgt_base:  rdata = wgt_base;
                off_ofm_base:  rdata = ofm_base;
                // start bit never holds, ctrl reads zero
                off_ctrl:      rdata = '0;
                off_status:    rdata = status_word;
                default:       rdata = '0;
            endcase
        end
    end

endmodule

// File: cu_layer_seq.sv
`timescale 1ns/1ps

module cu_layer_seq (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         stall,
    input  cu_pkg::dim_t in_height,
    input  cu_pkg::dim_t in_width,
    input  cu_pkg::dim_t in_ch,
    input  cu_pkg::dim_t out_ch,
    input  logic [3:0]   kernel_size,
    input  logic [3:0]   stride,
    output logic         busy,
    output logic         done,
    output logic         error,
    output logic         idx_valid,
    output logic         first,
    output logic         last,
    output cu_pkg::dim_t oc,
    output cu_pkg::dim_t oy,
    output cu_pkg::dim_t ox,
    output cu_pkg::dim_t ic,
    output cu_pkg::dim_t ky,
    output cu_pkg::dim_t kx,
    output cu_pkg::dim_t out_h,
    output cu_pkg::dim_t out_w,
    // steps still inside the address pipeline
    input  logic         drain
);
    import cu_pkg::*;

    logic [1:0] state;
    dim_t       k_dim;
    dim_t       s_dim;
    logic       cfg_bad;
    logic       advance;
    logic       kx_wrap;
    logic       ky_wrap;
    logic       ic_wrap;
    logic       ox_wrap;
    logic       oy_wrap;
    logic       oc_wrap;
    logic       step_last;

    assign k_dim = dim_t'(kernel_size);
    assign s_dim = dim_t'(stride);

    // reject zero sizes and kernels wider than the input
    assign cfg_bad = (in_height == '0) || (in_width == '0) || (in_ch == '0)
                  || (out_ch == '0) || (k_dim == '0) || (s_dim == '0)
                  || (k_dim > in_height) || (k_dim > in_width);

    // loop ends, innermost first
    assign kx_wrap = (kx == k_dim - 16'd1);
    assign ky_wrap = (ky == k_dim - 16'd1);
    assign ic_wrap = (ic == in_ch - 16'd1);
    assign ox_wrap = (ox == out_w - 16'd1);
    assign oy_wrap = (oy == out_h - 16'd1);
    assign oc_wrap = (oc == out_ch - 16'd1);

    assign step_last = kx_wrap && ky_wrap && ic_wrap && ox_wrap && oy_wrap && oc_wrap;

    assign busy      = (state != st_idle);
    assign idx_valid = (state == st_run);
    assign advance   = idx_valid && !stall;

    // accumulation boundaries over ic, ky, kx
    assign first = (ic == '0) && (ky == '0) && (kx == '0);
    assign last  = ic_wrap && ky_wrap && kx_wrap;

    //////////////////////////////
    // control FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            done  <= 1'b0;
            error <= 1'b0;
            out_h <= '0;
            out_w <= '0;
        end else begin
            done  <= 1'b0;
            error <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    if (cfg_bad) begin
                        error <= 1'b1;
                        state <= st_idle;
                    end else begin
                        // valid output positions per axis
                        out_h <= (in_height - k_dim) / s_dim + 16'd1;
                        out_w <= (in_width - k_dim) / s_dim + 16'd1;
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (advance && step_last) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    // wait for the address pipeline to empty
                    if (!drain) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////
    // loop counters
    //////////////////////////////

    // order oc, oy, ox, ic, ky, kx, kx fastest
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            oc <= '0;
            oy <= '0;
            ox <= '0;
            ic <= '0;
            ky <= '0;
            kx <= '0;
        end else if (state == st_setup) begin
            oc <= '0;
            oy <= '0;
            ox <= '0;
            ic <= '0;
            ky <= '0;
            kx <= '0;
        end else if (advance) begin
            kx <= kx_wrap ? '0 : kx + 16'd1;
            if (kx_wrap) begin
                ky <= ky_wrap ? '0 : ky + 16'd1;
            end
            if (kx_wrap && ky_wrap) begin
                ic <= ic_wrap ? '0 : ic + 16'd1;
            end
            if (last) begin
                ox <= ox_wrap ? '0 : ox + 16'd1;
            end
            if (last && ox_wrap) begin
                oy <= oy_wrap ? '0 : oy + 16'd1;
            end
            if (last && ox_wrap && oy_wrap) begin
                oc <= oc_wrap ? '0 : oc + 16'd1;
            end
        end
    end

endmodule

// File: cu_addr_gen.sv
`timescale 1ns/1ps

module cu_addr_gen (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall,
    input  logic          idx_valid,
    input  logic          first,
    input  logic          last,
    input  cu_pkg::dim_t  oc,
    input  cu_pkg::dim_t  oy,
    input  cu_pkg::dim_t  ox,
    input  cu_pkg::dim_t  ic,
    input  cu_pkg::dim_t  ky,
    input  cu_pkg::dim_t  kx,
    input  cu_pkg::dim_t  out_h,
    input  cu_pkg::dim_t  out_w,
    input  cu_pkg::dim_t  in_height,
    input  cu_pkg::dim_t  in_width,
    input  cu_pkg::dim_t  in_ch,
    input  logic [3:0]    kernel_size,
    input  logic [3:0]    stride,
    input  cu_pkg::addr_t ifm_base,
    input  cu_pkg::addr_t wgt_base,
    input  cu_pkg::addr_t ofm_base,
    output logic          step_valid,
    output logic          acc_first,
    output logic          acc_last,
    output logic          drain,
    output cu_pkg::addr_t ifm_addr,
    output cu_pkg::addr_t wgt_addr,
    output cu_pkg::addr_t ofm_addr
);
    import cu_pkg::*;

    addr_t iy;
    addr_t ix;
    addr_t ifm_row_d;
    addr_t wgt_row_d;
    addr_t ofm_row_d;

    // stage one registers
    logic  s1_valid;
    logic  s1_first;
    logic  s1_last;
    addr_t s1_ifm_row;
    addr_t s1_ix;
    addr_t s1_wgt_row;
    addr_t s1_kx;
    addr_t s1_ofm_row;
    addr_t s1_ox;

    // input window position
    assign iy = addr_t'(oy) * addr_t'(stride) + addr_t'(ky);
    assign ix = addr_t'(ox) * addr_t'(stride) + addr_t'(kx);

    // row indices, the column term is added in stage two
    assign ifm_row_d = addr_t'(ic) * addr_t'(in_height) + iy;
    assign wgt_row_d = (addr_t'(oc) * addr_t'(in_ch) + addr_t'(ic)) * addr_t'(kernel_size)
                     + addr_t'(ky);
    assign ofm_row_d = addr_t'(oc) * addr_t'(out_h) + addr_t'(oy);

    // whole pipe freezes under stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s1_first   <= 1'b0;
            s1_last    <= 1'b0;
            s1_ifm_row <= '0;
            s1_ix      <= '0;
            s1_wgt_row <= '0;
            s1_kx      <= '0;
            s1_ofm_row <= '0;
            s1_ox      <= '0;
        end else if (!stall) begin
            s1_valid   <= idx_valid;
            // flags only mean something on a real step
            s1_first   <= idx_valid && first;
            s1_last    <= idx_valid && last;
            s1_ifm_row <= ifm_row_d;
            s1_ix      <= ix;
            s1_wgt_row <= wgt_row_d;
            s1_kx      <= addr_t'(kx);
            s1_ofm_row <= ofm_row_d;
            s1_ox      <= addr_t'(ox);
        end
    end

    //////////////////////////////
    // stage two, final addresses
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_valid <= 1'b0;
            acc_first  <= 1'b0;
            acc_last   <= 1'b0;
            ifm_addr   <= '0;
            wgt_addr   <= '0;
            ofm_addr   <= '0;
        end else if (!stall) begin
            step_valid <= s1_valid;
            acc_first  <= s1_first;
            acc_last   <= s1_last;
            ifm_addr   <= ifm_base + s1_ifm_row * addr_t'(in_width) + s1_ix;
            wgt_addr   <= wgt_base + s1_wgt_row * addr_t'(kernel_size) + s1_kx;
            ofm_addr   <= ofm_base + s1_ofm_row * addr_t'(out_w) + s1_ox;
        end
    end

    // sequencer holds done until both stages are empty
    assign drain = s1_valid || step_valid;

endmodule

// File: cu_top.sv
`timescale 1ns/1ps

module cu_top (
    input  logic                          clk,
    input  logic                          rst,
    // configuration bus
    input  logic                          cs,
    input  logic                          we,
    input  logic [cu_pkg::csr_addr_w-1:0] addr,
    input  cu_pkg::csr_data_t             wdata,
    output cu_pkg::csr_data_t             rdata,
    // datapath back-pressure
    input  logic                          stall,
    // step stream
    output logic                          step_valid,
    output cu_pkg::addr_t                 ifm_addr,
    output cu_pkg::addr_t                 wgt_addr,
    output cu_pkg::addr_t                 ofm_addr,
    output logic                          acc_first,
    output logic                          acc_last,
    // decoded layer flags
    output logic [3:0]                    layer_type,
    output logic                          relu_en,
    output logic                          pool_en,
    output logic                          busy,
    output logic                          done
);
    import cu_pkg::*;

    // config fields
    dim_t       in_height;
    dim_t       in_width;
    dim_t       in_ch;
    dim_t       out_ch;
    logic [3:0] kernel_size;
    logic [3:0] stride;
    addr_t      ifm_base;
    addr_t      wgt_base;
    addr_t      ofm_base;
    logic       start;
    logic       error;

    // sequencer to address pipe
    logic       idx_valid;
    logic       first;
    logic       last;
    logic       drain;
    dim_t       oc;
    dim_t       oy;
    dim_t       ox;
    dim_t       ic;
    dim_t       ky;
    dim_t       kx;
    dim_t       out_h;
    dim_t       out_w;

    cu_config_csrs u_csrs (
        .clk, .rst, .cs, .we, .addr, .wdata, .rdata,
        .busy, .done, .error,
        .in_height, .in_width, .in_ch, .out_ch,
        .layer_type, .kernel_size, .stride, .relu_en, .pool_en,
        .ifm_base, .wgt_base, .ofm_base, .start
    );

    cu_layer_seq u_seq (
        .clk, .rst, .start, .stall,
        .in_height, .in_width, .in_ch, .out_ch, .kernel_size, .stride,
        .busy, .done, .error, .idx_valid, .first, .last,
        .oc, .oy, .ox, .ic, .ky, .kx, .out_h, .out_w, .drain
    );

    cu_addr_gen u_agen (
        .clk, .rst, .stall, .idx_valid, .first, .last,
        .oc, .oy, .ox, .ic, .ky, .kx, .out_h, .out_w,
        .in_height, .in_width, .in_ch, .kernel_size, .stride,
        .ifm_base, .wgt_base, .ofm_base,
        .step_valid, .acc_first, .acc_last, .drain,
        .ifm_addr, .wgt_addr, .ofm_addr
    );

endmodule

// File: cu_properties.sv
`timescale 1ns/1ps

module cu_properties (
    input logic          clk,
    input logic          rst,
    input logic          busy,
    input logic          done,
    input logic          stall,
    input logic          step_valid,
    input cu_pkg::addr_t ifm_addr,
    input cu_pkg::addr_t wgt_addr,
    input cu_pkg::addr_t ofm_addr
);

    //////////////////////////////
    // reset and pulse shape
    //////////////////////////////

    // nothing runs while reset is held
    reset_quiet: assert property (@(posedge clk) rst |-> !busy && !step_valid && !done)
        else $error("busy, step_valid or done high during reset");

    // done lasts one cycle only
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held high for more than one cycle");

    //////////////////////////////
    // back-pressure
    //////////////////////////////

    // a stalled step stays put with its addresses
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall && step_valid |=> step_valid && $stable(ifm_addr) && $stable(wgt_addr)
                                && $stable(ofm_addr))
        else $error("step moved or changed while stalled");

endmodule

bind cu_top cu_properties u_props (
    .clk, .rst, .busy, .done, .stall, .step_valid,
    .ifm_addr, .wgt_addr, .ofm_addr
);

// File: tb_cu_top.sv
`timescale 1ns/1ps

module tb_cu_top;
    import cu_pkg::*;

    localparam int n_rows    = 5;
    localparam int run_limit = 20000;
    localparam int busy_wait = 50;

    logic                  clk;
    logic                  rst;
    logic                  cs;
    logic                  we;
    logic [csr_addr_w-1:0] addr;
    csr_data_t             wdata;
    csr_data_t             rdata;
    logic                  stall;
    logic                  step_valid;
    addr_t                 ifm_addr;
    addr_t                 wgt_addr;
    addr_t                 ofm_addr;
    logic                  acc_first;
    logic                  acc_last;
    logic [3:0]            layer_type;
    logic                  relu_en;
    logic                  pool_en;
    logic                  busy;
    logic                  done;

    //////////////////////////////
    // layer table, one array per column
    //////////////////////////////

    // row 4 has a kernel taller than the input, rejected
    dim_t       row_h    [n_rows] = '{16'd6, 16'd7, 16'd4, 16'd8, 16'd3};
    dim_t       row_w    [n_rows] = '{16'd5, 16'd7, 16'd4, 16'd6, 16'd5};
    dim_t       row_ic   [n_rows] = '{16'd2, 16'd1, 16'd3, 16'd2, 16'd1};
    dim_t       row_oc   [n_rows] = '{16'd2, 16'd3, 16'd1, 16'd2, 16'd1};
    logic [3:0] row_k    [n_rows] = '{4'd3, 4'd3, 4'd1, 4'd2, 4'd4};
    logic [3:0] row_s    [n_rows] = '{4'd1, 4'd2, 4'd1, 4'd3, 4'd1};
    logic [3:0] row_type [n_rows] = '{4'd1, 4'd2, 4'd7, 4'd0, 4'd9};
    logic       row_relu [n_rows] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    logic       row_pool [n_rows] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
    addr_t      row_ifm  [n_rows] = '{32'h100, 32'h4000, 32'h0, 32'h1234, 32'h10};
    addr_t      row_wgt  [n_rows] = '{32'h2000, 32'h8000, 32'h55, 32'hF00, 32'h20};
    addr_t      row_ofm  [n_rows] = '{32'h8000, 32'hC000, 32'h999, 32'h7000, 32'h30};
    // oc * out_h * out_w * ic * k * k
    count_t     row_steps[n_rows] = '{32'd432, 32'd243, 32'd48, 32'd96, 32'd0};

    // reference step stream, loop order
    addr_t exp_ifm[$];
    addr_t exp_wgt[$];
    addr_t exp_ofm[$];
    logic  exp_first[$];
    logic  exp_last[$];

    int seed = 34801;
    int value_errs = 0;
    int other_errs = 0;

    cu_top uut (
        .clk, .rst, .cs, .we, .addr, .wdata, .rdata, .stall,
        .step_valid, .ifm_addr, .wgt_addr, .ofm_addr, .acc_first, .acc_last,
        .layer_type, .relu_en, .pool_en, .busy, .done
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input csr_data_t exp, input csr_data_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    //////////////////////////////
    // bus access
    //////////////////////////////

    // write lands on the rising edge in between
    task automatic bus_write(input logic [csr_addr_w-1:0] a, input csr_data_t d);
        @(negedge clk);
        cs    = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        cs = 1'b0;
        we = 1'b0;
    endtask

    // rdata is combinational, sampled mid low phase
    task automatic bus_read(input logic [csr_addr_w-1:0] a, output csr_data_t d);
        @(negedge clk);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        #1;
        d = rdata;
        @(negedge clk);
        cs = 1'b0;
    endtask

    function automatic logic [15:0] cfg_of(input int r);
        // reserved bits set on purpose, they read back raw
        return {row_type[r], row_k[r], row_s[r], row_relu[r], row_pool[r], 2'b11};
    endfunction

    // junk above each field width must not stick
    task automatic configure(input int r);
        bus_write(off_in_height, {16'hA5A5, row_h[r]});
        bus_write(off_in_width, {16'h5A5A, row_w[r]});
        bus_write(off_in_ch, {16'hFFFF, row_ic[r]});
        bus_write(off_out_ch, {16'h0F0F, row_oc[r]});
        bus_write(off_cfg, {16'hFFFF, cfg_of(r)});
        bus_write(off_ifm_base, row_ifm[r]);
        bus_write(off_wgt_base, row_wgt[r]);
        bus_write(off_ofm_base, row_ofm[r]);
        // unlisted offsets
        bus_write(6'h28, 32'hDEAD_BEEF);
        bus_write(6'h3C, 32'hCAFE_F00D);
    endtask

    task automatic check_readback(input int r);
        csr_data_t d;
        logic [15:0] cfg;
        cfg = cfg_of(r);
        bus_read(off_in_height, d);
        check_word($sformatf("row %0d in_height", r), {16'h0, row_h[r]}, d);
        bus_read(off_in_width, d);
        check_word($sformatf("row %0d in_width", r), {16'h0, row_w[r]}, d);
        bus_read(off_in_ch, d);
        check_word($sformatf("row %0d in_ch", r), {16'h0, row_ic[r]}, d);
        bus_read(off_out_ch, d);
        check_word($sformatf("row %0d out_ch", r), {16'h0, row_oc[r]}, d);
        bus_read(off_cfg, d);
        check_word($sformatf("row %0d cfg", r), {16'h0, cfg}, d);
        bus_read(off_ifm_base, d);
        check_word($sformatf("row %0d ifm_base", r), row_ifm[r], d);
        bus_read(off_wgt_base, d);
        check_word($sformatf("row %0d wgt_base", r), row_wgt[r], d);
        bus_read(off_ofm_base, d);
        check_word($sformatf("row %0d ofm_base", r), row_ofm[r], d);
        bus_read(6'h28, d);
        check_word($sformatf("row %0d offset 0x28", r), '0, d);
        bus_read(6'h3C, d);
        check_word($sformatf("row %0d offset 0x3c", r), '0, d);
        // idle bus, addressed register must not leak out
        // in_height is never zero in the table
        @(negedge clk);
        cs   = 1'b0;
        we   = 1'b0;
        addr = off_in_height;
        #1;
        check_word($sformatf("row %0d rdata with cs low", r), '0, rdata);
        // field decode follows the cfg layout
        check_word($sformatf("row %0d layer_type", r), csr_data_t'(cfg[15:12]),
                   csr_data_t'(layer_type));
        check_flag($sformatf("row %0d relu_en", r), cfg[3], relu_en);
        check_flag($sformatf("row %0d pool_en", r), cfg[2], pool_en);
    endtask

    //////////////////////////////
    // reference address model
    //////////////////////////////

    task automatic build_model(input int r);
        int h;
        int w;
        int icn;
        int k;
        int s;
        int oh;
        int ow;
        int oc;
        int oy;
        int ox;
        int ic;
        int ky;
        int kx;
        exp_ifm.delete();
        exp_wgt.delete();
        exp_ofm.delete();
        exp_first.delete();
        exp_last.delete();
        if (row_steps[r] == 0) begin
            return;
        end
        h   = int'(row_h[r]);
        w   = int'(row_w[r]);
        icn = int'(row_ic[r]);
        k   = int'(row_k[r]);
        s   = int'(row_s[r]);
        oh  = (h - k) / s + 1;
        ow  = (w - k) / s + 1;
        for (oc = 0; oc < int'(row_oc[r]); oc++) begin
            for (oy = 0; oy < oh; oy++) begin
                for (ox = 0; ox < ow; ox++) begin
                    for (ic = 0; ic < icn; ic++) begin
                        for (ky = 0; ky < k; ky++) begin
                            for (kx = 0; kx < k; kx++) begin
                                exp_ifm.push_back(row_ifm[r] +
                                    addr_t'((ic * h + oy * s + ky) * w + ox * s + kx));
                                exp_wgt.push_back(row_wgt[r] +
                                    addr_t'(((oc * icn + ic) * k + ky) * k + kx));
                                exp_ofm.push_back(row_ofm[r] + addr_t'((oc * oh + oy) * ow + ox));
                                exp_first.push_back(ic == 0 && ky == 0 && kx == 0);
                                exp_last.push_back(ic == icn - 1 && ky == k - 1 && kx == k - 1);
                            end
                        end
                    end
                end
            end
        end
        check_count($sformatf("row %0d model size", r), row_steps[r], count_t'(exp_ifm.size()));
    endtask

    // one step taken at the coming rising edge
    task automatic consume_step(input int r, input int n);
        if (exp_ifm.size() == 0) begin
            $display("row %0d: step %0d came out after the reference stream ended", r, n);
            other_errs++;
        end else begin
            check_addr($sformatf("row %0d step %0d ifm_addr", r, n), exp_ifm.pop_front(), ifm_addr);
            check_addr($sformatf("row %0d step %0d wgt_addr", r, n), exp_wgt.pop_front(), wgt_addr);
            check_addr($sformatf("row %0d step %0d ofm_addr", r, n), exp_ofm.pop_front(), ofm_addr);
            check_flag($sformatf("row %0d step %0d acc_first", r, n),
                       exp_first.pop_front(), acc_first);
            check_flag($sformatf("row %0d step %0d acc_last", r, n), exp_last.pop_front(), acc_last);
        end
    endtask

    //////////////////////////////
    // layer run
    //////////////////////////////

    task automatic run_layer(input int r);
        int        waited;
        int        cycles;
        int        n;
        logic      done_seen;
        logic      valid_seen;
        csr_data_t st;
        csr_data_t exp_st;
        n          = 0;
        done_seen  = 1'b0;
        valid_seen = 1'b0;
        stall      = 1'b0;
        bus_write(off_ctrl, 32'h1);
        waited = 0;
        while (!busy && waited < busy_wait) begin
            @(negedge clk);
            waited++;
        end
        if (!busy) begin
            $display("row %0d: busy never rose after the start write", r);
            other_errs++;
            return;
        end
        cycles = 0;
        // outputs are steady at the falling edge
        while (busy && cycles < run_limit) begin
            done_seen  = done_seen | done;
            valid_seen = valid_seen | step_valid;
            // second start while the layer runs
            if (cycles == 4) begin
                cs    = 1'b1;
                we    = 1'b1;
                addr  = off_ctrl;
                wdata = 32'h1;
            end else if (cycles == 5) begin
                cs = 1'b0;
                we = 1'b0;
            end
            stall = (($random(seed) & 3) == 0);
            if (step_valid && !stall) begin
                consume_step(r, n);
                n++;
            end
            @(negedge clk);
            cycles++;
        end
        // done and busy fall on the same edge
        done_seen = done_seen | done;
        cs        = 1'b0;
        we        = 1'b0;
        stall     = 1'b0;
        if (busy) begin
            $display("row %0d: layer still busy after %0d cycles", r, run_limit);
            other_errs++;
        end
        check_count($sformatf("row %0d consumed steps", r), row_steps[r], count_t'(n));
        bus_read(off_status, st);
        exp_st = '0;
        if (row_steps[r] != 0) begin
            exp_st[stat_done_bit] = 1'b1;
            check_flag($sformatf("row %0d done pulse", r), 1'b1, done_seen);
        end else begin
            exp_st[stat_error_bit] = 1'b1;
            check_flag($sformatf("row %0d done pulse", r), 1'b0, done_seen);
            check_flag($sformatf("row %0d step_valid seen", r), 1'b0, valid_seen);
        end
        check_word($sformatf("row %0d status", r), exp_st, st);
    endtask

    initial begin
        rst   = 1'b1;
        cs    = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        stall = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            configure(r);
            check_readback(r);
            build_model(r);
            run_layer(r);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
cu_pkg.sv
cu_config_csrs.sv
cu_layer_seq.sv
cu_addr_gen.sv
cu_top.sv
cu_properties.sv
tb_cu_top.sv

// File: Makefile
# Verilator flow for the layer control unit

VERILATOR ?= verilator
TOP       ?= tb_cu_top
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -F -- '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
